//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := axil_sram_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/axil_sram_checks.svh
`ifndef AXIL_SRAM_CHECKS_SVH
`define AXIL_SRAM_CHECKS_SVH

int check_count = 0;
int error_count = 0;
// errors seen before the current test started
int test_error_base = 0;

task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                          input logic [DATA_WIDTH-1:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

// single control bits such as valid and ready
task automatic check_state(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic test_done(input string name);
  int errs;
  errs = error_count - test_error_base;
  $display("test %-10s %s, %0d errors", name, (errs == 0) ? "ok" : "mismatch", errs);
  test_error_base = error_count;
endtask

`endif

//--- bench/axil_sram_tb.sv
module axil_sram_tb;
  import axil_sram_pkg::*;

  localparam int ADDR_WIDTH   = DEFAULT_ADDR_WIDTH;
  localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
  localparam int MEM_WORDS    = DEFAULT_MEM_WORDS;
  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int MEM_AW       = $clog2(MEM_WORDS);
  localparam int WORD_SPACE   = 1 << (ADDR_WIDTH - $clog2(STRB_WIDTH));
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;

  // loop counts per test
  localparam int N_RESET = 8;
  localparam int N_FULL  = 24;
  localparam int N_STRB  = 32;
  localparam int N_RANGE = 12;
  localparam int N_STALL = 24;
  localparam int N_MIX   = 200;
  localparam int TOTAL_TXNS = N_RESET + 2 * N_FULL + 2 * N_STRB + 3 * N_RANGE
                            + 2 * N_STALL + N_MIX;
  localparam int TIMEOUT = (TOTAL_TXNS * 40 + RESET_CYCLES) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  axil_resp_t            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_WIDTH-1:0] rdata;
  axil_resp_t            rresp;
  logic                  rvalid;
  logic                  rready;

  logic [DATA_WIDTH-1:0] model [MEM_WORDS];
  logic [31:0]           lcg_state = 32'd18799;
  bit                    stall_en = 1'b0;

  `include "axil_sram_checks.svh"

  axil_sram_top #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits, the low LCG bits repeat quickly
  function automatic int rand_below(input int n);
    return int'((rand32() >> 8) % n);
  endfunction

  function automatic logic pick_ready();
    if (!stall_en) begin
      return 1'b1;
    end
    return rand_below(4) != 0;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] byte_addr(input int word);
    return ADDR_WIDTH'(word * STRB_WIDTH);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_strobed(input logic [DATA_WIDTH-1:0] old,
      input logic [DATA_WIDTH-1:0] data, input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] mask;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return (old & ~mask) | (data & mask);
  endfunction

  // order 0 sends AW and W together, 1 AW first, 2 W first
  task automatic write_word(input int word, input logic [DATA_WIDTH-1:0] data,
                            input logic [STRB_WIDTH-1:0] strb, input int order);
    bit         aw_sent;
    bit         w_sent;
    bit         seen;
    bit         taken;
    axil_resp_t held;
    axil_resp_t got;
    aw_sent = 1'b0;
    w_sent  = 1'b0;
    while (!(aw_sent && w_sent)) begin
      @(posedge clk);
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_sent = 1'b1;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_sent = 1'b1;
      end
      if (!aw_sent && !awvalid && (order != 2 || w_sent)) begin
        awaddr  <= byte_addr(word);
        awvalid <= 1'b1;
      end
      if (!w_sent && !wvalid && (order != 1 || aw_sent)) begin
        wdata  <= data;
        wstrb  <= strb;
        wvalid <= 1'b1;
      end
    end
    seen  = 1'b0;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      if (seen) begin
        check_state("bvalid", bvalid, 1'b1);
        check_resp("bresp", bresp, held);
      end
      if (bvalid && bready) begin
        taken = 1'b1;
        got = bresp;
        bready <= 1'b0;
      end else begin
        if (bvalid && !seen) begin
          seen = 1'b1;
          held = bresp;
        end
        bready <= pick_ready();
      end
    end
    check_resp("bresp", got, (word < MEM_WORDS) ? RESP_OKAY : RESP_SLVERR);
    if (word < MEM_WORDS) begin
      model[MEM_AW'(word)] = merge_strobed(model[MEM_AW'(word)], data, strb);
    end
  endtask

  task automatic read_word(input int word);
    bit                    seen;
    bit                    taken;
    axil_resp_t            held_resp;
    logic [DATA_WIDTH-1:0] held_data;
    logic [DATA_WIDTH-1:0] exp_data;
    @(posedge clk);
    araddr  <= byte_addr(word);
    arvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(arvalid && arready));
    arvalid <= 1'b0;
    seen  = 1'b0;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      if (seen) begin
        check_state("rvalid", rvalid, 1'b1);
        check_resp("rresp", rresp, held_resp);
        check_data("rdata", rdata, held_data);
      end
      if (rvalid && rready) begin
        taken = 1'b1;
        rready <= 1'b0;
      end else begin
        if (rvalid && !seen) begin
          seen      = 1'b1;
          held_resp = rresp;
          held_data = rdata;
        end
        rready <= pick_ready();
      end
    end
    exp_data = (word < MEM_WORDS) ? model[MEM_AW'(word)] : '0;
    check_data("rdata", rdata, exp_data);
    check_resp("rresp", rresp, (word < MEM_WORDS) ? RESP_OKAY : RESP_SLVERR);
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog expired at time %0t, a handshake never completed", $time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int word;
    int words[$];
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = '0;
    end
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_state("bvalid", bvalid, 1'b0);
    check_state("rvalid", rvalid, 1'b0);
    check_state("awready", awready, 1'b0);
    check_state("wready", wready, 1'b0);
    check_state("arready", arready, 1'b0);
    for (int i = 0; i < N_RESET; i++) begin
      read_word(rand_below(MEM_WORDS));
    end
    test_done("reset");

    for (int i = 0; i < N_FULL; i++) begin
      word = rand_below(MEM_WORDS);
      words.push_back(word);
      write_word(word, DATA_WIDTH'(rand32()), '1, 0);
    end
    foreach (words[i]) begin
      read_word(words[i]);
    end
    test_done("full");

    // small window so partial writes land on the same words
    for (int i = 0; i < N_STRB; i++) begin
      word = rand_below(16);
      write_word(word, DATA_WIDTH'(rand32()), STRB_WIDTH'(rand_below(1 << STRB_WIDTH)), 0);
      read_word(word);
    end
    test_done("strobe");

    for (int i = 0; i < N_RANGE; i++) begin
      word = MEM_WORDS + rand_below(WORD_SPACE - MEM_WORDS);
      write_word(word, DATA_WIDTH'(rand32()), '1, rand_below(3));
      read_word(word);
      // the aliased in-range word must be untouched
      read_word(word % MEM_WORDS);
    end
    test_done("range");

    stall_en = 1'b1;
    for (int i = 0; i < N_STALL; i++) begin
      word = rand_below(MEM_WORDS);
      write_word(word, DATA_WIDTH'(rand32()), '1, 1 + i % 2);
      read_word(word);
    end
    test_done("stall");

    for (int i = 0; i < N_MIX; i++) begin
      if (rand_below(10) == 0) begin
        word = MEM_WORDS + rand_below(WORD_SPACE - MEM_WORDS);
      end else begin
        word = rand_below(MEM_WORDS);
      end
      if (rand_below(2) == 0) begin
        write_word(word, DATA_WIDTH'(rand32()), STRB_WIDTH'(rand_below(1 << STRB_WIDTH)),
                   rand_below(3));
      end else begin
        read_word(word);
      end
    end
    test_done("mix");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- design/axil_sram_bridge.sv
module axil_sram_bridge #(
  parameter int ADDR_WIDTH = 16,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic [ADDR_WIDTH-1:0]     awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [DATA_WIDTH-1:0]     wdata,
  input  logic [DATA_WIDTH/8-1:0]   wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_sram_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,

  input  logic [ADDR_WIDTH-1:0]     araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [DATA_WIDTH-1:0]     rdata,
  output axil_sram_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready,

  sram_port_if.host                 sram
);
  import axil_sram_pkg::*;

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int BYTE_BITS  = $clog2(STRB_WIDTH);
  localparam int WORD_WIDTH = ADDR_WIDTH - BYTE_BITS;
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  // one extra bit so a depth filling the whole word space still compares
  localparam logic [WORD_WIDTH:0] MEM_LIMIT = (WORD_WIDTH + 1)'(MEM_WORDS);

  typedef enum logic [2:0] {
    S_IDLE,
    S_COLLECT_WR,
    S_ISSUE,
    S_AWAIT_RD,
    S_RESPOND
  } state_t;

  state_t                state;

  logic [WORD_WIDTH-1:0] aw_word;
  logic [WORD_WIDTH-1:0] ar_word;
  logic [WORD_WIDTH-1:0] wr_word;
  logic [WORD_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic                  is_write;
  logic                  cmd_valid_q;

  logic                  aw_done;
  logic                  w_done;
  logic                  prefer_rd;

  logic                  aw_fire;
  logic                  w_fire;
  logic                  ar_fire;
  logic                  cmd_fire;
  logic                  resp_fire;
  logic                  wr_complete;
  logic                  wr_in_range;
  logic                  ar_in_range;
  logic                  wr_pending;
  logic                  rd_turn;
  logic                  wr_turn;

  function automatic logic in_range(input logic [WORD_WIDTH-1:0] word);
    return {1'b0, word} < MEM_LIMIT;
  endfunction

  // word address, byte offset dropped
  assign aw_word = awaddr[ADDR_WIDTH-1:BYTE_BITS];
  assign ar_word = araddr[ADDR_WIDTH-1:BYTE_BITS];

  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign ar_fire   = arvalid && arready;
  assign cmd_fire  = cmd_valid_q && sram.cmd_ready;
  assign resp_fire = sram.resp_valid && sram.resp_ready;

  // AW may land in the same cycle as the closing W
  assign wr_word     = aw_done ? addr_q : aw_word;
  assign wr_in_range = in_range(wr_word);
  assign ar_in_range = in_range(ar_word);
  assign wr_complete = (state == S_COLLECT_WR) && (aw_done || aw_fire) && (w_done || w_fire);

  // alternate when both sides are waiting
  assign wr_pending = awvalid || wvalid;
  assign rd_turn    = arvalid && (prefer_rd || !wr_pending);
  assign wr_turn    = wr_pending && !rd_turn;

  assign sram.cmd_valid   = cmd_valid_q;
  assign sram.cmd_addr    = addr_q[MEM_AW-1:0];
  assign sram.cmd_wr_en   = is_write;
  assign sram.cmd_wr_data = wdata_q;
  assign sram.cmd_wr_strb = wstrb_q;
  assign sram.resp_ready  = (state == S_AWAIT_RD);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      awready     <= 1'b0;
      wready      <= 1'b0;
      arready     <= 1'b0;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
      cmd_valid_q <= 1'b0;
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
      prefer_rd   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (ar_fire) begin
            arready   <= 1'b0;
            prefer_rd <= 1'b0;
            if (ar_in_range) begin
              cmd_valid_q <= 1'b1;
              state       <= S_ISSUE;
            end else begin
              rvalid <= 1'b1;
              state  <= S_RESPOND;
            end
          end else if (!arready && wr_turn) begin
            awready   <= 1'b1;
            wready    <= 1'b1;
            prefer_rd <= 1'b1;
            state     <= S_COLLECT_WR;
          end else begin
            arready <= rd_turn;
          end
        end
        S_COLLECT_WR: begin
          if (aw_fire) begin
            awready <= 1'b0;
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            wready <= 1'b0;
            w_done <= 1'b1;
          end
          if (wr_complete) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            if (wr_in_range) begin
              cmd_valid_q <= 1'b1;
              state       <= S_ISSUE;
            end else begin
              bvalid <= 1'b1;
              state  <= S_RESPOND;
            end
          end
        end
        S_ISSUE: begin
          if (cmd_fire) begin
            cmd_valid_q <= 1'b0;
            if (is_write) begin
              bvalid <= 1'b1;
              state  <= S_RESPOND;
            end else begin
              state <= S_AWAIT_RD;
            end
          end
        end
        S_AWAIT_RD: begin
          if (resp_fire) begin
            rvalid <= 1'b1;
            state  <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // captured transaction and response payload
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q   <= ar_word;
      is_write <= 1'b0;
    end
    if (aw_fire) begin
      addr_q <= aw_word;
    end
    if (state == S_COLLECT_WR) begin
      is_write <= 1'b1;
    end
    if (w_fire) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (resp_fire) begin
      rdata <= sram.resp_rd_data;
      rresp <= RESP_OKAY;
    end else if (ar_fire && !ar_in_range) begin
      rdata <= '0;
      rresp <= RESP_SLVERR;
    end
    if (cmd_fire && is_write) begin
      bresp <= RESP_OKAY;
    end else if (wr_complete && !wr_in_range) begin
      bresp <= RESP_SLVERR;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  // out-of-range words must never reach the store
  a_cmd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    sram.cmd_valid |-> in_range(addr_q));

endmodule

//--- design/axil_sram_pkg.sv
package axil_sram_pkg;

  // AXI-lite response codes, only the two this slave returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // byte address on the AXI side
  localparam int DEFAULT_ADDR_WIDTH = 16;

  localparam int DEFAULT_DATA_WIDTH = 32;

  // SRAM depth in words, keep it a power of two
  localparam int DEFAULT_MEM_WORDS = 256;

endpackage

//--- design/axil_sram_top.sv
module axil_sram_top #(
  parameter int ADDR_WIDTH = axil_sram_pkg::DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = axil_sram_pkg::DEFAULT_DATA_WIDTH,
  parameter int MEM_WORDS  = axil_sram_pkg::DEFAULT_MEM_WORDS
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic [ADDR_WIDTH-1:0]     awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [DATA_WIDTH-1:0]     wdata,
  input  logic [DATA_WIDTH/8-1:0]   wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_sram_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,

  input  logic [ADDR_WIDTH-1:0]     araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [DATA_WIDTH-1:0]     rdata,
  output axil_sram_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  // word index into the store
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

  sram_port_if #(
    .WORD_ADDR_WIDTH(MEM_ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH)
  ) sram ();

  axil_sram_bridge #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_bridge (
    .clk    (clk),
    .rst_n  (rst_n),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .sram   (sram.host)
  );

  sram_store #(
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_store (
    .clk  (clk),
    .rst_n(rst_n),
    .sram (sram.mem)
  );

endmodule

//--- design/sram_port_if.sv
interface sram_port_if #(
  parameter int WORD_ADDR_WIDTH = 8,
  parameter int DATA_WIDTH      = 32
);

  logic                      cmd_valid;
  logic                      cmd_ready;
  logic [WORD_ADDR_WIDTH-1:0] cmd_addr;
  logic                      cmd_wr_en;
  logic [DATA_WIDTH-1:0]     cmd_wr_data;
  logic [DATA_WIDTH/8-1:0]   cmd_wr_strb;

  // read data only, writes get no response
  logic                      resp_valid;
  logic                      resp_ready;
  logic [DATA_WIDTH-1:0]     resp_rd_data;

  modport host (
    output cmd_valid, cmd_addr, cmd_wr_en, cmd_wr_data, cmd_wr_strb, resp_ready,
    input  cmd_ready, resp_valid, resp_rd_data
  );

  modport mem (
    input  cmd_valid, cmd_addr, cmd_wr_en, cmd_wr_data, cmd_wr_strb, resp_ready,
    output cmd_ready, resp_valid, resp_rd_data
  );

endinterface

//--- design/sram_store.sv
module sram_store #(
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input logic    clk,
  input logic    rst_n,
  sram_port_if.mem sram
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  logic                  resp_valid_q;
  logic [DATA_WIDTH-1:0] rd_data_q;
  logic                  cmd_fire;

  // starts out cleared in simulation
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // a response leaving this cycle frees the slot for the next command
  assign sram.cmd_ready = !resp_valid_q || sram.resp_ready;
  assign cmd_fire       = sram.cmd_valid && sram.cmd_ready;

  assign sram.resp_valid   = resp_valid_q;
  assign sram.resp_rd_data = rd_data_q;

  // byte lanes under strobe
  always_ff @(posedge clk) begin
    if (cmd_fire && sram.cmd_wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (sram.cmd_wr_strb[b]) begin
          mem[sram.cmd_addr][b*8 +: 8] <= sram.cmd_wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && !sram.cmd_wr_en) begin
      rd_data_q <= mem[sram.cmd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else if (cmd_fire && !sram.cmd_wr_en) begin
      resp_valid_q <= 1'b1;
    end else if (sram.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  // held response stays put until the host takes it
  a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sram.resp_valid && !sram.resp_ready |=> sram.resp_valid && $stable(sram.resp_rd_data));

endmodule

//--- sim.f
+incdir+bench
design/axil_sram_pkg.sv
design/sram_port_if.sv
design/axil_sram_bridge.sv
design/sram_store.sv
design/axil_sram_top.sv
bench/axil_sram_tb.sv
